/* tb.f */
vec_elem_pkg.sv
elem_ctrl_if.sv
elem_stream_if.sv
elem_sequencer.sv
elem_operand_shift.sv
elem_reduce_alu.sv
vec_elem_unit.sv
tb_vec_elem_unit.sv

/* Makefile */
# Verilator flow for the vector reduction element unit

TOP = tb_vec_elem_unit
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* tb_vec_elem_unit.sv */
// testbench for the vector reduction element unit
// random reductions checked against a reference model, with latency and overlap checks
`timescale 1ns/1ps

module tb_vec_elem_unit;
    import vec_elem_pkg::*;

    localparam int VREG_W         = 128;
    localparam int VL_W           = $clog2(VREG_W / 8 + 1);
    localparam int NUM_OPS        = 64;
    localparam int TIMEOUT_CYCLES = 40 * NUM_OPS + 100;

    logic                   clk_i;
    logic                   async_rst_ni;
    logic                   op_rdy_i;
    logic                   op_ack_o;
    red_op_e                op_i;
    sew_e                   sew_i;
    logic [VL_W-1:0]        vl_i;
    logic [VREG_ADDR_W-1:0] vs1_i;
    logic [VREG_ADDR_W-1:0] vs2_i;
    logic [VREG_ADDR_W-1:0] vreg_rd_addr_o;
    logic [VREG_W-1:0]      vreg_rd_data_i;
    logic                   xreg_valid_o;
    logic [XLEN-1:0]        xreg_o;

    // register file model and the queue of operations in flight
    logic [VREG_W-1:0] regs [32];
    logic [XLEN-1:0]   exp_q [$];
    int                lat_q [$];
    int                accept_q [$];
    string             name_q [$];
    string             phase_name = "reset";
    int                cycle_cnt = 0;
    int                prev_accept = 0;
    int                prev_n = 0;
    int                max_inflight = 0;
    logic              rdy_held = 1'b0;

    vec_elem_unit #(.VREG_W(VREG_W)) i_vec_elem_unit (.*);

    // the register file answers in the same cycle
    assign vreg_rd_data_i = regs[vreg_rd_addr_o];

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic int elem_count(input sew_e sew);
        case (sew)
            SEW_8:   return VREG_W / 8;
            SEW_16:  return VREG_W / 16;
            default: return VREG_W / 32;
        endcase
    endfunction

    ////////////////////////////////////////
    // reference model

    // biasing by the sign bit turns a signed compare into an unsigned one
    function automatic logic [XLEN-1:0] reduce_model(input red_op_e op, input sew_e sew,
            input int vl, input logic [VREG_W-1:0] data, input logic [VREG_W-1:0] init_reg);
        int                w;
        int                i;
        longint            mask;
        longint            top;
        longint            acc;
        longint            e;
        logic [VREG_W-1:0] sh;
        w    = VREG_W / elem_count(sew);
        mask = (longint'(1) << w) - 1;
        top  = longint'(1) << (w - 1);
        acc  = longint'({32'd0, init_reg[31:0]}) & mask;
        for (i = 0; i < vl; i++) begin
            sh = data >> (i * w);
            e  = longint'({32'd0, sh[31:0]}) & mask;
            case (op)
                RED_SUM:  acc = (acc + e) & mask;
                RED_AND:  acc = acc & e;
                RED_OR:   acc = acc | e;
                RED_XOR:  acc = acc ^ e;
                RED_MINU: acc = (e < acc) ? e : acc;
                RED_MAXU: acc = (e > acc) ? e : acc;
                RED_MIN:  acc = ((e ^ top) < (acc ^ top)) ? e : acc;
                default:  acc = ((e ^ top) > (acc ^ top)) ? e : acc;
            endcase
        end
        return XLEN'((acc ^ top) - top);
    endfunction

    ////////////////////////////////////////
    // checks

    task automatic stop_on_failure();
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_result(input string name, input logic [XLEN-1:0] expected,
                                input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s result: expected %h, actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("[ERROR] %s cycles: expected %0d, actual %0d", name, expected, actual);
            stop_on_failure();
        end
    endtask

    ////////////////////////////////////////
    // stimulus helpers

    task automatic fill_regs();
        int r;
        int j;
        for (r = 0; r < 32; r++) begin
            for (j = 0; j < VREG_W / 32; j++) begin
                regs[r][j*32 +: 32] = $urandom;
            end
        end
    endtask

    // returns on the edge where the operation is accepted
    task automatic issue_op(input red_op_e op, input sew_e sew, input int vl);
        op_i     <= op;
        sew_i    <= sew;
        vl_i     <= VL_W'(vl);
        vs1_i    <= VREG_ADDR_W'($urandom);
        vs2_i    <= VREG_ADDR_W'($urandom);
        op_rdy_i <= 1'b1;
        @(posedge clk_i);
        while (!op_ack_o) begin
            @(posedge clk_i);
        end
    endtask

    task automatic wait_drain();
        @(posedge clk_i);
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
    endtask

    // monitor that samples every output at the rising edge
    always @(posedge clk_i) begin : monitor
        int    n;
        string name;
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end else if (xreg_valid_o && exp_q.size() == 0) begin
            $display("xreg_valid_o went high with no operation in flight");
            stop_on_failure();
        end else if (xreg_valid_o) begin
            name = name_q.pop_front();
            check_result(name, exp_q.pop_front(), xreg_o);
            check_latency(name, lat_q.pop_front(), cycle_cnt - accept_q.pop_front());
        end
        if (!async_rst_ni && op_ack_o) begin
            $display("op_ack_o was high while reset was asserted");
            stop_on_failure();
        end
        if (!op_rdy_i) begin
            rdy_held = 1'b0;
        end
        if (op_rdy_i && op_ack_o) begin
            n    = elem_count(sew_i);
            name = $sformatf("%s %s %s vl=%0d", phase_name, op_i.name(), sew_i.name(), vl_i);
            // with op_rdy_i held, the next accept lands on the last element
            if (rdy_held) begin
                check_latency({name, " spacing"}, prev_n + 1, cycle_cnt - prev_accept);
            end
            exp_q.push_back(reduce_model(op_i, sew_i, int'(vl_i), regs[vs2_i], regs[vs1_i]));
            lat_q.push_back(n + 3);
            accept_q.push_back(cycle_cnt);
            name_q.push_back(name);
            if (exp_q.size() > max_inflight) begin
                max_inflight = exp_q.size();
            end
            rdy_held    = 1'b1;
            prev_accept = cycle_cnt;
            prev_n      = n;
        end
    end

    initial begin
        int   s;
        int   o;
        int   k;
        sew_e sew;
        void'($urandom(16172));
        async_rst_ni <= 1'b0;
        op_rdy_i     <= 1'b0;
        op_i         <= RED_SUM;
        sew_i        <= SEW_8;
        vl_i         <= '0;
        vs1_i        <= '0;
        vs2_i        <= '0;
        fill_regs();
        repeat (2) @(posedge clk_i);
        async_rst_ni <= 1'b1;

        // every operation at every width, full vector
        phase_name = "full";
        for (s = 0; s < 3; s++) begin
            for (o = 0; o < 8; o++) begin
                issue_op(red_op_e'(o), sew_e'(s), elem_count(sew_e'(s)));
                op_rdy_i <= 1'b0;
                wait_drain();
            end
        end

        // random vl with every eighth one zero
        phase_name = "random vl";
        fill_regs();
        for (k = 0; k < 24; k++) begin
            sew = sew_e'($urandom_range(2, 0));
            issue_op(red_op_e'($urandom_range(7, 0)), sew,
                     (k % 8 == 0) ? 0 : int'($urandom_range(elem_count(sew), 0)));
            op_rdy_i <= 1'b0;
            wait_drain();
        end

        // op_rdy_i held high across operations
        phase_name = "back to back";
        fill_regs();
        for (k = 0; k < 16; k++) begin
            sew = sew_e'($urandom_range(2, 0));
            issue_op(red_op_e'($urandom_range(7, 0)), sew,
                     int'($urandom_range(elem_count(sew), 0)));
        end
        op_rdy_i <= 1'b0;
        wait_drain();

        if (max_inflight < 2) begin
            $display("back to back operations never overlapped in the pipeline");
            stop_on_failure();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* vec_elem_unit.sv */
// vector reduction element unit, top level
// sequencer, operand stage and reduction ALU in a three stage chain
`timescale 1ns/1ps

module vec_elem_unit #(
    parameter int unsigned  VREG_W    = 128,
    localparam int unsigned ELEMS_MAX = VREG_W / 8,
    localparam int unsigned VL_W      = $clog2(ELEMS_MAX + 1)
) (
    input  logic                                clk_i,
    input  logic                                async_rst_ni,
    input  logic                                op_rdy_i,
    output logic                                op_ack_o,
    input  vec_elem_pkg::red_op_e               op_i,
    input  vec_elem_pkg::sew_e                  sew_i,
    input  logic [VL_W-1:0]                     vl_i,
    input  logic [vec_elem_pkg::VREG_ADDR_W-1:0] vs1_i,
    input  logic [vec_elem_pkg::VREG_ADDR_W-1:0] vs2_i,
    output logic [vec_elem_pkg::VREG_ADDR_W-1:0] vreg_rd_addr_o,
    input  logic [VREG_W-1:0]                   vreg_rd_data_i,
    output logic                                xreg_valid_o,
    output logic [vec_elem_pkg::XLEN-1:0]       xreg_o
);

    elem_ctrl_if   i_ctrl_if ();
    elem_stream_if i_stream_if ();

    elem_sequencer #(
        .VREG_W (VREG_W)
    ) i_elem_sequencer (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .vl_i           (vl_i),
        .vs1_i          (vs1_i),
        .vs2_i          (vs2_i),
        .op_ack_o       (op_ack_o),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .ctrl           (i_ctrl_if.seq)
    );

    elem_operand_shift #(
        .VREG_W (VREG_W)
    ) i_elem_operand_shift (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .vreg_rd_data_i (vreg_rd_data_i),
        .ctrl           (i_ctrl_if.opnd),
        .stream         (i_stream_if.src)
    );

    elem_reduce_alu i_elem_reduce_alu (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .stream       (i_stream_if.dst),
        .xreg_valid_o (xreg_valid_o),
        .xreg_o       (xreg_o)
    );

endmodule

/* elem_reduce_alu.sv */
// reduction ALU
// folds the element stream into an accumulator and returns the scalar result
`timescale 1ns/1ps

module elem_reduce_alu (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,
    elem_stream_if.dst                    stream,
    output logic                          xreg_valid_o,
    output logic [vec_elem_pkg::XLEN-1:0] xreg_o
);
    import vec_elem_pkg::*;

    // extend the low element bits to XLEN+1 as signed or unsigned
    function automatic logic [XLEN:0] widen(input logic [XLEN-1:0] v, input sew_e sew,
                                            input logic sgn);
        unique case (sew)
            SEW_8:   widen = {{(XLEN - 7){sgn & v[7]}}, v[7:0]};
            SEW_16:  widen = {{(XLEN - 15){sgn & v[15]}}, v[15:0]};
            default: widen = {sgn & v[XLEN-1], v};
        endcase
    endfunction

    logic [XLEN-1:0] acc_q;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] comb_res;
    logic [XLEN-1:0] acc_d;
    logic [XLEN:0]   elem_w;
    logic [XLEN:0]   base_w;
    logic [XLEN-1:0] acc_sext;
    logic            signed_cmp;
    logic            elem_lt;
    logic            elem_gt;

    // the first element of an operation starts from the init word
    assign base = stream.first ? stream.init : acc_q;

    assign signed_cmp = (stream.cmd.op == RED_MIN) | (stream.cmd.op == RED_MAX);
    assign elem_w     = widen(stream.elem, stream.cmd.sew, signed_cmp);
    assign base_w     = widen(base, stream.cmd.sew, signed_cmp);
    assign elem_lt    = $signed(elem_w) < $signed(base_w);
    assign elem_gt    = $signed(elem_w) > $signed(base_w);

    always_comb begin
        unique case (stream.cmd.op)
            RED_SUM:  comb_res = stream.elem + base;
            RED_AND:  comb_res = stream.elem & base;
            RED_OR:   comb_res = stream.elem | base;
            RED_XOR:  comb_res = stream.elem ^ base;
            RED_MINU,
            RED_MIN:  comb_res = elem_lt ? stream.elem : base;
            default:  comb_res = elem_gt ? stream.elem : base;
        endcase
    end

    // elements at or past vl leave the accumulator unchanged
    assign acc_d    = stream.active ? comb_res : base;
    assign acc_sext = XLEN'(widen(acc_d, stream.cmd.sew, 1'b1));

    always_ff @(posedge clk_i) begin
        if (stream.valid) begin
            acc_q <= acc_d;
        end
        if (stream.valid & stream.last) begin
            xreg_o <= acc_sext;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            xreg_valid_o <= 1'b0;
        end else begin
            xreg_valid_o <= stream.valid & stream.last;
        end
    end

endmodule

/* elem_operand_shift.sv */
// operand stage
// holds the data vector and init word, emits one element per issue onto the stream
`timescale 1ns/1ps

module elem_operand_shift #(
    parameter int unsigned VREG_W = 128
) (
    input  logic              clk_i,
    input  logic              async_rst_ni,
    input  logic [VREG_W-1:0] vreg_rd_data_i,
    elem_ctrl_if.opnd         ctrl,
    elem_stream_if.src        stream
);
    import vec_elem_pkg::*;

    logic [VREG_W-1:0] shift_q;
    logic [XLEN-1:0]   init_q;
    logic [XLEN-1:0]   elem_low;

    // lowest element at the current width, zero-extended
    always_comb begin
        unique case (ctrl.cmd.sew)
            SEW_8:   elem_low = XLEN'(shift_q[7:0]);
            SEW_16:  elem_low = XLEN'(shift_q[15:0]);
            default: elem_low = shift_q[XLEN-1:0];
        endcase
    end

    ////////////////////////////////////////
    // operand registers

    always_ff @(posedge clk_i) begin
        if (ctrl.load_vec) begin
            shift_q <= vreg_rd_data_i;
        end else if (ctrl.issue) begin
            unique case (ctrl.cmd.sew)
                SEW_8:   shift_q <= shift_q >> 8;
                SEW_16:  shift_q <= shift_q >> 16;
                default: shift_q <= shift_q >> 32;
            endcase
        end
        // init comes from element 0 of vs1
        if (ctrl.load_init) begin
            init_q <= vreg_rd_data_i[XLEN-1:0];
        end
    end

    ////////////////////////////////////////
    // stream output stage

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            stream.valid <= 1'b0;
        end else begin
            stream.valid <= ctrl.issue;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl.issue) begin
            stream.elem   <= elem_low;
            stream.first  <= ctrl.first;
            stream.last   <= ctrl.last;
            stream.active <= ctrl.active;
            stream.cmd    <= ctrl.cmd;
        end
    end

    assign stream.init = init_q;

endmodule

/* elem_sequencer.sv */
// element sequencer
// accepts reductions, fetches the operand registers and issues one element per cycle
`timescale 1ns/1ps

module elem_sequencer #(
    parameter int unsigned  VREG_W    = 128,
    localparam int unsigned ELEMS_MAX = VREG_W / 8,
    localparam int unsigned VL_W      = $clog2(ELEMS_MAX + 1)
) (
    input  logic                                clk_i,
    input  logic                                async_rst_ni,
    input  logic                                op_rdy_i,
    input  vec_elem_pkg::red_op_e               op_i,
    input  vec_elem_pkg::sew_e                  sew_i,
    input  logic [VL_W-1:0]                     vl_i,
    input  logic [vec_elem_pkg::VREG_ADDR_W-1:0] vs1_i,
    input  logic [vec_elem_pkg::VREG_ADDR_W-1:0] vs2_i,
    output logic                                op_ack_o,
    output logic [vec_elem_pkg::VREG_ADDR_W-1:0] vreg_rd_addr_o,
    elem_ctrl_if.seq                            ctrl
);
    import vec_elem_pkg::*;

    // fetch data vector, fetch init and issue element 0, then stream the rest
    typedef enum logic [1:0] {
        PH_DATA,
        PH_INIT,
        PH_STREAM
    } phase_e;

    logic                   busy_q;
    logic                   out_of_reset_q;
    phase_e                 phase_q;
    logic [VL_W-1:0]        count_q;

    elem_cmd_t              cmd_q;
    logic [VL_W-1:0]        vl_q;
    logic [VREG_ADDR_W-1:0] vs1_q;
    logic [VREG_ADDR_W-1:0] vs2_q;

    logic [VL_W-1:0]        n_elems;
    logic                   issuing;
    logic                   last_elem;
    logic                   accept;

    // elements per register at the current width
    always_comb begin
        unique case (cmd_q.sew)
            SEW_8:   n_elems = VL_W'(ELEMS_MAX);
            SEW_16:  n_elems = VL_W'(ELEMS_MAX / 2);
            default: n_elems = VL_W'(ELEMS_MAX / 4);
        endcase
    end

    assign issuing   = busy_q & (phase_q != PH_DATA);
    assign last_elem = issuing & (count_q == n_elems - VL_W'(1));

    // a new operation may start while the last element goes out
    assign op_ack_o = out_of_reset_q & (~busy_q | last_elem);
    assign accept   = op_rdy_i & op_ack_o;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            out_of_reset_q <= 1'b0;
            busy_q         <= 1'b0;
            phase_q        <= PH_DATA;
            count_q        <= '0;
        end else begin
            out_of_reset_q <= 1'b1;
            if (accept) begin
                busy_q  <= 1'b1;
                phase_q <= PH_DATA;
                count_q <= '0;
            end else if (busy_q) begin
                if (phase_q == PH_DATA) begin
                    phase_q <= PH_INIT;
                end else begin
                    phase_q <= PH_STREAM;
                    count_q <= count_q + VL_W'(1);
                    if (last_elem) begin
                        busy_q <= 1'b0;
                    end
                end
            end
        end
    end

    // operation fields, held until the next accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd_q <= '{op: op_i, sew: sew_i};
            vl_q  <= vl_i;
            vs1_q <= vs1_i;
            vs2_q <= vs2_i;
        end
    end

    assign vreg_rd_addr_o = (phase_q == PH_INIT) ? vs1_q : vs2_q;

    assign ctrl.load_vec  = busy_q & (phase_q == PH_DATA);
    assign ctrl.load_init = busy_q & (phase_q == PH_INIT);
    assign ctrl.issue     = issuing;
    assign ctrl.first     = issuing & (count_q == '0);
    assign ctrl.last      = last_elem;
    assign ctrl.active    = count_q < vl_q;
    assign ctrl.cmd       = cmd_q;

endmodule

/* elem_stream_if.sv */
// element stream from the operand stage to the reduction ALU
`timescale 1ns/1ps

interface elem_stream_if;
    import vec_elem_pkg::*;

    logic            valid;
    // element, zero-extended from its width
    logic [XLEN-1:0] elem;
    // initial value of the reduction
    logic [XLEN-1:0] init;
    logic            first;
    logic            last;
    logic            active;
    elem_cmd_t       cmd;

    modport src (output valid, elem, init, first, last, active, cmd);
    modport dst (input valid, elem, init, first, last, active, cmd);

endinterface

/* elem_ctrl_if.sv */
// issue control from the element sequencer to the operand stage
`timescale 1ns/1ps

interface elem_ctrl_if;
    import vec_elem_pkg::*;

    // register fetch strobes
    logic      load_vec;
    logic      load_init;

    // one element per cycle while issue is high
    logic      issue;
    logic      first;
    logic      last;
    logic      active;
    elem_cmd_t cmd;

    modport seq (output load_vec, load_init, issue, first, last, active, cmd);
    modport opnd (input load_vec, load_init, issue, first, last, active, cmd);

endinterface

/* vec_elem_pkg.sv */
// vector reduction element unit
// shared widths, encodings and the per-element command word
package vec_elem_pkg;

    // scalar result width
    localparam int unsigned XLEN = 32;

    // vector register address width
    localparam int unsigned VREG_ADDR_W = 5;

    // element width encoding
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    // reduction operations
    typedef enum logic [2:0] {
        RED_SUM  = 3'd0,
        RED_AND  = 3'd1,
        RED_OR   = 3'd2,
        RED_XOR  = 3'd3,
        RED_MINU = 3'd4,
        RED_MIN  = 3'd5,
        RED_MAXU = 3'd6,
        RED_MAX  = 3'd7
    } red_op_e;

    // travels with every element, so two operations can overlap in the pipeline
    typedef struct packed {
        red_op_e op;
        sew_e    sew;
    } elem_cmd_t;

endpackage
